//--- Bender.yml
package:
  name: rv_execute

sources:
  - hw/rv_core_pkg.sv
  - hw/rv_isa_pkg.sv
  - hw/alu.sv
  - hw/forward_unit.sv
  - hw/divider.sv
  - hw/ex_mem_reg.sv
  - hw/execute.sv
  - target: simulation
    files:
      - sim/execute_checker.sv
      - sim/tb_execute.sv

//--- hw/alu.sv
module alu (
    input  rv_core_pkg::word_t   in1,
    input  rv_core_pkg::word_t   in2,
    input  rv_core_pkg::opcode_t opcode,
    input  rv_core_pkg::funct3_t funct3,
    input  rv_core_pkg::funct7_t funct7,
    output rv_core_pkg::word_t   result,
    output logic                 branch_taken
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    logic [2*xlen-1:0] mul_a;
    logic [2*xlen-1:0] mul_b;
    logic [2*xlen-1:0] product;
    logic              is_alt;
    logic              lt_s;
    logic              lt_u;

    // one shared multiplier, the operand extension picks the mulh flavour
    // rs1 is zero extended only for mulhu, rs2 sign extended only for mulh
    assign mul_a   = (funct3 == f3_mulhu) ? {{xlen{1'b0}}, in1} : {{xlen{in1[xlen-1]}}, in1};
    assign mul_b   = (funct3 == f3_mulh) ? {{xlen{in2[xlen-1]}}, in2} : {{xlen{1'b0}}, in2};
    assign product = mul_a * mul_b;

    // sub and sra share the alternate funct7
    assign is_alt = (funct7 == f7_alt);
    assign lt_s   = $signed(in1) < $signed(in2);
    assign lt_u   = in1 < in2;

    always_comb begin
        // address arithmetic for auipc, loads, stores, jumps and branches
        result = in1 + in2;
        if (opcode == op_lui) begin
            result = in2;
        end else if (opcode == op_r && funct7 == f7_muldiv) begin
            // div and rem come from the divider, only multiplies here
            case (funct3)
                f3_mul:  result = product[xlen-1:0];
                default: result = product[2*xlen-1:xlen];
            endcase
        end else if (opcode == op_r || opcode == op_i) begin
            case (funct3)
                f3_add_sub: begin
                    // immediates never subtract
                    if (opcode == op_r && is_alt) begin
                        result = in1 - in2;
                    end else begin
                        result = in1 + in2;
                    end
                end
                f3_sll:     result = in1 << in2[4:0];
                f3_slt:     result = {{(xlen-1){1'b0}}, lt_s};
                f3_sltu:    result = {{(xlen-1){1'b0}}, lt_u};
                f3_xor:     result = in1 ^ in2;
                f3_srl_sra: begin
                    if (is_alt) begin
                        result = $signed(in1) >>> in2[4:0];
                    end else begin
                        result = in1 >> in2[4:0];
                    end
                end
                f3_or:      result = in1 | in2;
                default:    result = in1 & in2;
            endcase
        end
    end

    always_comb begin
        branch_taken = 1'b0;
        if (opcode == op_jal || opcode == op_jalr) begin
            branch_taken = 1'b1;
        end else if (opcode == op_branch) begin
            case (funct3)
                f3_beq:  branch_taken = (in1 == in2);
                f3_bne:  branch_taken = (in1 != in2);
                f3_blt:  branch_taken = lt_s;
                f3_bge:  branch_taken = !lt_s;
                f3_bltu: branch_taken = lt_u;
                f3_bgeu: branch_taken = !lt_u;
                // 010 and 011 are not branches
                default: branch_taken = 1'b0;
            endcase
        end
    end

endmodule

//--- hw/divider.sv
module divider #(
    parameter int div_bits_per_cycle = 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               is_signed,
    input  rv_core_pkg::word_t dividend,
    input  rv_core_pkg::word_t divisor,
    output rv_core_pkg::word_t quotient,
    output rv_core_pkg::word_t remainder,
    output logic               done
);
    import rv_core_pkg::*;

    // iterations per divide, and a counter wide enough to hold it
    localparam int steps = xlen / div_bits_per_cycle;
    localparam int cnt_w = $clog2(steps) + 1;

    typedef enum logic [1:0] {
        idle,
        run,
        finish
    } state_t;

    state_t           state;
    logic [cnt_w-1:0] count;
    // magnitudes and result signs latched at start
    word_t            dsr_q;
    word_t            quo_q;
    word_t            rem_q;
    logic             q_neg;
    logic             r_neg;
    logic             a_neg;
    logic             b_neg;
    word_t            quo_nxt;
    word_t            rem_nxt;
    logic [xlen:0]    shifted;
    logic [xlen:0]    trial;

    assign a_neg = is_signed & dividend[xlen-1];
    assign b_neg = is_signed & divisor[xlen-1];

    // div_bits_per_cycle restoring steps unrolled into one cycle
    // quo holds the dividend bits still to shift in, then the quotient
    always_comb begin
        quo_nxt = quo_q;
        rem_nxt = rem_q;
        shifted = '0;
        trial   = '0;
        for (int i = 0; i < div_bits_per_cycle; i++) begin
            shifted = {rem_nxt, quo_nxt[xlen-1]};
            trial   = shifted - {1'b0, dsr_q};
            quo_nxt = {quo_nxt[xlen-2:0], ~trial[xlen]};
            // keep the partial remainder when the trial went negative
            rem_nxt = trial[xlen] ? shifted[xlen-1:0] : trial[xlen-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            count <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= run;
                        count <= cnt_w'(steps - 1);
                    end
                end
                run: begin
                    count <= count - 1'b1;
                    if (count == '0) begin
                        state <= finish;
                    end
                end
                // start is ignored here so a following divide starts fresh
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            dsr_q <= b_neg ? -divisor : divisor;
            quo_q <= a_neg ? -dividend : dividend;
            rem_q <= '0;
            // a zero divisor leaves the all ones quotient unsigned
            q_neg <= (a_neg ^ b_neg) && (divisor != '0);
            // remainder takes the dividend sign, also for x / 0
            r_neg <= a_neg;
        end else if (state == run) begin
            quo_q <= quo_nxt;
            rem_q <= rem_nxt;
        end
    end

    // sign correction while in finish
    // -2^31 / -1 wraps back to -2^31 with remainder 0 by itself
    assign quotient  = q_neg ? -quo_q : quo_q;
    assign remainder = r_neg ? -rem_q : rem_q;
    assign done      = (state == finish);

endmodule

//--- hw/ex_mem_reg.sv
module ex_mem_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  bubble,
    input  rv_core_pkg::word_t    alu_result,
    input  rv_core_pkg::funct3_t  funct3,
    input  logic                  mem_wr_en,
    input  rv_core_pkg::word_t    store_data,
    input  logic                  reg_wr_en,
    input  rv_core_pkg::wb_sel_t  wb_sel,
    input  rv_core_pkg::reg_idx_t rd,
    input  rv_core_pkg::word_t    pc_plus4,
    output rv_core_pkg::word_t    alu_result_mem,
    output rv_core_pkg::funct3_t  funct3_mem,
    output logic                  mem_wr_en_mem,
    output rv_core_pkg::word_t    store_data_mem,
    output logic                  reg_wr_en_mem,
    output rv_core_pkg::wb_sel_t  wb_sel_mem,
    output rv_core_pkg::reg_idx_t rd_mem,
    output rv_core_pkg::word_t    pc_plus4_mem
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_result_mem <= '0;
            funct3_mem     <= '0;
            mem_wr_en_mem  <= 1'b0;
            store_data_mem <= '0;
            reg_wr_en_mem  <= 1'b0;
            wb_sel_mem     <= '0;
            rd_mem         <= '0;
            pc_plus4_mem   <= '0;
        end else if (bubble) begin
            // a nop: no store, no register write, every field zero
            alu_result_mem <= '0;
            funct3_mem     <= '0;
            mem_wr_en_mem  <= 1'b0;
            store_data_mem <= '0;
            reg_wr_en_mem  <= 1'b0;
            wb_sel_mem     <= '0;
            rd_mem         <= '0;
            pc_plus4_mem   <= '0;
        end else begin
            alu_result_mem <= alu_result;
            funct3_mem     <= funct3;
            mem_wr_en_mem  <= mem_wr_en;
            store_data_mem <= store_data;
            reg_wr_en_mem  <= reg_wr_en;
            wb_sel_mem     <= wb_sel;
            rd_mem         <= rd;
            pc_plus4_mem   <= pc_plus4;
        end
    end

endmodule

//--- hw/execute.sv
module execute #(
    parameter int div_bits_per_cycle = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::word_t    rs1_data,
    input  rv_core_pkg::word_t    rs2_data,
    input  rv_core_pkg::word_t    imm,
    input  rv_core_pkg::word_t    pc,
    input  rv_core_pkg::word_t    pc_plus4,
    input  rv_core_pkg::opcode_t  opcode,
    input  rv_core_pkg::funct3_t  funct3,
    input  rv_core_pkg::funct7_t  funct7,
    input  rv_core_pkg::reg_idx_t rs1,
    input  rv_core_pkg::reg_idx_t rs2,
    input  rv_core_pkg::reg_idx_t rd,
    input  logic                  pc_rs1_sel,
    input  logic                  imm_rs2_sel,
    input  logic                  jump_branch_sel,
    input  logic                  mem_wr_en,
    input  logic                  reg_wr_en,
    input  rv_core_pkg::wb_sel_t  wb_sel,
    input  rv_core_pkg::word_t    wb_data,
    input  rv_core_pkg::reg_idx_t rd_wb,
    input  logic                  reg_wr_en_wb,
    output rv_core_pkg::word_t    alu_result_mem,
    output rv_core_pkg::word_t    store_data_mem,
    output rv_core_pkg::word_t    pc_plus4_mem,
    output rv_core_pkg::funct3_t  funct3_mem,
    output logic                  mem_wr_en_mem,
    output logic                  reg_wr_en_mem,
    output rv_core_pkg::wb_sel_t  wb_sel_mem,
    output rv_core_pkg::reg_idx_t rd_mem,
    output logic                  pc_sel,
    output rv_core_pkg::word_t    jump_addr,
    output logic                  div_stall
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    fwd_sel_t fwd1_sel;
    fwd_sel_t fwd2_sel;
    word_t    rs1_fwd;
    word_t    rs2_fwd;
    word_t    in1;
    word_t    in2;
    word_t    alu_result;
    word_t    ex_result;
    word_t    quotient;
    word_t    remainder;
    logic     branch_taken;
    logic     div_start;
    logic     div_signed;
    logic     div_done;

    forward_unit u_forward (
        .rs1           (rs1),
        .rs2           (rs2),
        .rd_mem        (rd_mem),
        .reg_wr_en_mem (reg_wr_en_mem),
        .rd_wb         (rd_wb),
        .reg_wr_en_wb  (reg_wr_en_wb),
        .fwd1_sel      (fwd1_sel),
        .fwd2_sel      (fwd2_sel)
    );

    // register operand after forwarding, same mux for both sources
    function automatic word_t fwd_mux(
        input fwd_sel_t sel,
        input word_t    reg_data,
        input word_t    mem_data,
        input word_t    wb_val
    );
        case (sel)
            fwd_mem: return mem_data;
            fwd_wb:  return wb_val;
            default: return reg_data;
        endcase
    endfunction

    assign rs1_fwd = fwd_mux(fwd1_sel, rs1_data, alu_result_mem, wb_data);
    // rs2_fwd is also the store data
    assign rs2_fwd = fwd_mux(fwd2_sel, rs2_data, alu_result_mem, wb_data);
    // pc and imm slots carry no register, so forwarding is bypassed
    assign in1     = pc_rs1_sel ? pc : rs1_fwd;
    assign in2     = imm_rs2_sel ? imm : rs2_fwd;

    alu u_alu (
        .in1          (in1),
        .in2          (in2),
        .opcode       (opcode),
        .funct3       (funct3),
        .funct7       (funct7),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    // div, divu, rem, remu all have funct3 bit 2 set
    assign div_start  = (opcode == op_r) && (funct7 == f7_muldiv) && funct3[2];
    assign div_signed = (funct3 == f3_div) || (funct3 == f3_rem);

    divider #(
        .div_bits_per_cycle (div_bits_per_cycle)
    ) u_divider (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (in1),
        .divisor   (in2),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done)
    );

    // held until the divider's done cycle, upstream freezes ID/EX meanwhile
    assign div_stall = div_start & ~div_done;

    // funct3 bit 1 separates rem from div
    assign ex_result = !div_start ? alu_result : (funct3[1] ? remainder : quotient);

    // jal and branches add the immediate to pc, jalr uses the alu sum
    assign jump_addr = jump_branch_sel ? pc + imm : {alu_result[xlen-1:1], 1'b0};
    assign pc_sel    = branch_taken & ~div_stall;

    ex_mem_reg u_ex_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .bubble         (div_stall),
        .alu_result     (ex_result),
        .funct3         (funct3),
        .mem_wr_en      (mem_wr_en),
        .store_data     (rs2_fwd),
        .reg_wr_en      (reg_wr_en),
        .wb_sel         (wb_sel),
        .rd             (rd),
        .pc_plus4       (pc_plus4),
        .alu_result_mem (alu_result_mem),
        .funct3_mem     (funct3_mem),
        .mem_wr_en_mem  (mem_wr_en_mem),
        .store_data_mem (store_data_mem),
        .reg_wr_en_mem  (reg_wr_en_mem),
        .wb_sel_mem     (wb_sel_mem),
        .rd_mem         (rd_mem),
        .pc_plus4_mem   (pc_plus4_mem)
    );

endmodule

//--- hw/forward_unit.sv
module forward_unit (
    input  rv_core_pkg::reg_idx_t rs1,
    input  rv_core_pkg::reg_idx_t rs2,
    input  rv_core_pkg::reg_idx_t rd_mem,
    input  logic                  reg_wr_en_mem,
    input  rv_core_pkg::reg_idx_t rd_wb,
    input  logic                  reg_wr_en_wb,
    output rv_core_pkg::fwd_sel_t fwd1_sel,
    output rv_core_pkg::fwd_sel_t fwd2_sel
);
    import rv_core_pkg::*;

    // the instruction in EX/MEM is younger than the one in writeback,
    // so its value wins when both write the same register
    function automatic fwd_sel_t pick(
        input reg_idx_t src,
        input reg_idx_t mem_dst,
        input logic     mem_we,
        input reg_idx_t wb_dst,
        input logic     wb_we
    );
        fwd_sel_t sel;
        sel = fwd_none;
        // x0 is hardwired, a write to it is never real data
        if (src != '0) begin
            if (mem_we && mem_dst == src) begin
                sel = fwd_mem;
            end else if (wb_we && wb_dst == src) begin
                sel = fwd_wb;
            end
        end
        return sel;
    endfunction

    // the pc and imm overrides are applied later in execute
    assign fwd1_sel = pick(rs1, rd_mem, reg_wr_en_mem, rd_wb, reg_wr_en_wb);
    // also steers the store data
    assign fwd2_sel = pick(rs2, rd_mem, reg_wr_en_mem, rd_wb, reg_wr_en_wb);

endmodule

//--- hw/rv_core_pkg.sv
package rv_core_pkg;

    // datapath width of the core
    localparam int xlen = 32;

    // one datapath word
    typedef logic [xlen-1:0] word_t;
    // architectural register index, x0..x31
    typedef logic [4:0]      reg_idx_t;

    // instruction fields as decoded upstream
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;
    typedef logic [6:0]      opcode_t;

    // writeback source code, carried through EX untouched
    typedef logic [1:0]      wb_sel_t;

    // operand source picked by the forwarding unit
    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_t;

endpackage

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes seen by the execute stage
    localparam rv_core_pkg::opcode_t op_r      = 7'b0110011;
    localparam rv_core_pkg::opcode_t op_i      = 7'b0010011;
    localparam rv_core_pkg::opcode_t op_lui    = 7'b0110111;
    localparam rv_core_pkg::opcode_t op_auipc  = 7'b0010111;
    localparam rv_core_pkg::opcode_t op_jal    = 7'b1101111;
    localparam rv_core_pkg::opcode_t op_jalr   = 7'b1100111;
    localparam rv_core_pkg::opcode_t op_branch = 7'b1100011;
    localparam rv_core_pkg::opcode_t op_load   = 7'b0000011;
    localparam rv_core_pkg::opcode_t op_store  = 7'b0100011;

    // integer alu operations, shared by op_r and op_i
    localparam rv_core_pkg::funct3_t f3_add_sub = 3'b000;
    localparam rv_core_pkg::funct3_t f3_sll     = 3'b001;
    localparam rv_core_pkg::funct3_t f3_slt     = 3'b010;
    localparam rv_core_pkg::funct3_t f3_sltu    = 3'b011;
    localparam rv_core_pkg::funct3_t f3_xor     = 3'b100;
    localparam rv_core_pkg::funct3_t f3_srl_sra = 3'b101;
    localparam rv_core_pkg::funct3_t f3_or      = 3'b110;
    localparam rv_core_pkg::funct3_t f3_and     = 3'b111;

    // branch conditions
    localparam rv_core_pkg::funct3_t f3_beq  = 3'b000;
    localparam rv_core_pkg::funct3_t f3_bne  = 3'b001;
    localparam rv_core_pkg::funct3_t f3_blt  = 3'b100;
    localparam rv_core_pkg::funct3_t f3_bge  = 3'b101;
    localparam rv_core_pkg::funct3_t f3_bltu = 3'b110;
    localparam rv_core_pkg::funct3_t f3_bgeu = 3'b111;

    // m extension, only valid with f7_muldiv
    localparam rv_core_pkg::funct3_t f3_mul    = 3'b000;
    localparam rv_core_pkg::funct3_t f3_mulh   = 3'b001;
    localparam rv_core_pkg::funct3_t f3_mulhsu = 3'b010;
    localparam rv_core_pkg::funct3_t f3_mulhu  = 3'b011;
    localparam rv_core_pkg::funct3_t f3_div    = 3'b100;
    localparam rv_core_pkg::funct3_t f3_divu   = 3'b101;
    localparam rv_core_pkg::funct3_t f3_rem    = 3'b110;
    localparam rv_core_pkg::funct3_t f3_remu   = 3'b111;

    // funct7 variants
    localparam rv_core_pkg::funct7_t f7_base   = 7'b0000000;
    localparam rv_core_pkg::funct7_t f7_alt    = 7'b0100000;
    localparam rv_core_pkg::funct7_t f7_muldiv = 7'b0000001;

endpackage

//--- list.f
hw/rv_core_pkg.sv
hw/rv_isa_pkg.sv
hw/alu.sv
hw/forward_unit.sv
hw/divider.sv
hw/ex_mem_reg.sv
hw/execute.sv
sim/execute_checker.sv
sim/tb_execute.sv

//--- sim/execute_checker.sv
module execute_checker #(
    parameter int div_bits_per_cycle = 1
) (
    input logic                  clk, rst_n,
    input rv_core_pkg::word_t    rs1_data, rs2_data, imm, pc, pc_plus4, wb_data,
    input rv_core_pkg::opcode_t  opcode,
    input rv_core_pkg::funct3_t  funct3, funct3_mem,
    input rv_core_pkg::funct7_t  funct7,
    input rv_core_pkg::reg_idx_t rs1, rs2, rd, rd_wb, rd_mem,
    input rv_core_pkg::wb_sel_t  wb_sel, wb_sel_mem,
    input logic                  pc_rs1_sel, imm_rs2_sel, jump_branch_sel, mem_wr_en, reg_wr_en,
    input logic                  reg_wr_en_wb, mem_wr_en_mem, reg_wr_en_mem, pc_sel, div_stall,
    input rv_core_pkg::word_t    alu_result_mem, store_data_mem, pc_plus4_mem, jump_addr
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    // one idle cycle plus one cycle per group of quotient bits
    localparam int stall_len = xlen / div_bits_per_cycle + 1;

    int    err_count = 0;
    int    run_len;
    word_t op1;
    word_t op2;
    word_t st_data;
    word_t expect_res;
    word_t div_a;
    word_t div_b;
    logic  is_div;
    logic  taken;
    logic  mem_busy;

    task automatic report_mismatch(input string field);
        err_count++;
        $error("** Error %0t: %s mismatch", $time, field);
    endtask

    // newest producer first, x0 never forwards
    function automatic word_t fwd_val(input reg_idx_t src, input word_t reg_data);
        if (src != '0 && reg_wr_en_mem && rd_mem == src) begin
            return alu_result_mem;
        end
        if (src != '0 && reg_wr_en_wb && rd_wb == src) begin
            return wb_data;
        end
        return reg_data;
    endfunction

    // rv32im result, wide math in longint keeps the high product bits
    function automatic word_t ref_result(input word_t a, input word_t b);
        longint sa;
        longint sb;
        longint ua;
        longint ub;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = longint'(a);
        ub = longint'(b);
        if (opcode == op_lui) begin
            return b;
        end
        if (opcode == op_r && funct7 == f7_muldiv) begin
            case (funct3)
                f3_mul:    return a * b;
                f3_mulh:   return word_t'((sa * sb) >> 32);
                f3_mulhsu: return word_t'((sa * ub) >> 32);
                f3_mulhu:  return word_t'((ua * ub) >> 32);
                // x / 0 gives all ones, -2^31 / -1 wraps to -2^31 rem 0 in 64 bits
                f3_div:    return (b == '0) ? '1 : word_t'(sa / sb);
                f3_divu:   return (b == '0) ? '1 : word_t'(ua / ub);
                f3_rem:    return (b == '0) ? a : word_t'(sa % sb);
                default:   return (b == '0) ? a : word_t'(ua % ub);
            endcase
        end
        // loads, stores, auipc and jumps only need the address sum
        if (opcode != op_r && opcode != op_i) begin
            return a + b;
        end
        case (funct3)
            f3_add_sub: return (opcode == op_r && funct7 == f7_alt) ? a - b : a + b;
            f3_sll:     return a << b[4:0];
            f3_slt:     return word_t'(sa < sb);
            f3_sltu:    return word_t'(a < b);
            f3_xor:     return a ^ b;
            f3_srl_sra: return (funct7 == f7_alt) ? word_t'(sa >>> b[4:0]) : a >> b[4:0];
            f3_or:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic logic ref_taken(input word_t a, input word_t b);
        if (opcode == op_jal || opcode == op_jalr) begin
            return 1'b1;
        end
        if (opcode != op_branch) begin
            return 1'b0;
        end
        case (funct3)
            f3_beq:  return a == b;
            f3_bne:  return a != b;
            f3_blt:  return $signed(a) < $signed(b);
            f3_bge:  return $signed(a) >= $signed(b);
            f3_bltu: return a < b;
            f3_bgeu: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    always_comb begin
        st_data  = fwd_val(rs2, rs2_data);
        op1      = pc_rs1_sel ? pc : fwd_val(rs1, rs1_data);
        op2      = imm_rs2_sel ? imm : st_data;
        is_div   = opcode == op_r && funct7 == f7_muldiv
                   && funct3 inside {f3_div, f3_divu, f3_rem, f3_remu};
        taken    = ref_taken(op1, op2);
        mem_busy = |{alu_result_mem, store_data_mem, pc_plus4_mem, funct3_mem,
                     mem_wr_en_mem, reg_wr_en_mem, wb_sel_mem, rd_mem};
        // in the done cycle the result comes from the operands seen at the start
        if (is_div && run_len != 0) begin
            expect_res = ref_result(div_a, div_b);
        end else begin
            expect_res = ref_result(op1, op2);
        end
    end

    // stall run length, operands latched on the first stall cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_len <= 0;
        end else begin
            run_len <= div_stall ? run_len + 1 : 0;
            if (div_stall && run_len == 0) begin
                div_a <= op1;
                div_b <= op2;
            end
        end
    end

    assert property (@(posedge clk) !rst_n |-> !mem_busy && !div_stall)
        else report_mismatch("reset state");

    assert property (@(posedge clk) disable iff (!rst_n) div_stall |=> !mem_busy)
        else report_mismatch("bubble");

    assert property (@(posedge clk) disable iff (!rst_n)
        !div_stall |=> alu_result_mem == $past(expect_res))
        else report_mismatch("alu_result_mem");

    assert property (@(posedge clk) disable iff (!rst_n)
        !div_stall |=> store_data_mem == $past(st_data))
        else report_mismatch("store_data_mem");

    assert property (@(posedge clk) disable iff (!rst_n)
        !div_stall |=> {rd_mem, wb_sel_mem, funct3_mem, mem_wr_en_mem, reg_wr_en_mem, pc_plus4_mem}
            == $past({rd, wb_sel, funct3, mem_wr_en, reg_wr_en, pc_plus4}))
        else report_mismatch("pass-through fields");

    assert property (@(posedge clk) disable iff (!rst_n) pc_sel == (taken && !div_stall))
        else report_mismatch("pc_sel");

    assert property (@(posedge clk) disable iff (!rst_n)
        !is_div |-> jump_addr == (jump_branch_sel ? pc + imm : {expect_res[xlen-1:1], 1'b0}))
        else report_mismatch("jump_addr");

    assert property (@(posedge clk) disable iff (!rst_n) $fell(div_stall) |-> run_len == stall_len)
        else report_mismatch("div_stall length");

endmodule

bind execute execute_checker #(
    .div_bits_per_cycle (div_bits_per_cycle)
) u_checker (.*);

//--- sim/tb_execute.sv
module tb_execute;
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    localparam int bits_per_cycle = 4;
    localparam int clk_period     = 8;
    localparam int num_instr      = 400;
    // worst case every instruction divides, plus reset and drain cycles
    localparam int max_cycles     = num_instr * (xlen / bits_per_cycle + 3) + 20;

    logic        clk;
    logic        rst_n;
    word_t       rs1_data, rs2_data, imm, pc, pc_plus4, wb_data;
    opcode_t     opcode;
    funct3_t     funct3, funct3_mem;
    funct7_t     funct7;
    reg_idx_t    rs1, rs2, rd, rd_wb, rd_mem;
    wb_sel_t     wb_sel, wb_sel_mem;
    logic        pc_rs1_sel, imm_rs2_sel, jump_branch_sel, mem_wr_en, reg_wr_en, reg_wr_en_wb;
    logic        mem_wr_en_mem, reg_wr_en_mem, pc_sel, div_stall;
    word_t       alu_result_mem, store_data_mem, pc_plus4_mem, jump_addr;
    logic [31:0] lfsr = 32'he351_0339;

    execute #(
        .div_bits_per_cycle (bits_per_cycle)
    ) UUT (
        .*
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1, one shift per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic clear_inputs();
        {rs1_data, rs2_data, imm, pc, pc_plus4, wb_data} = '0;
        {opcode, funct3, funct7, rs1, rs2, rd, rd_wb, wb_sel} = '0;
        {pc_rs1_sel, imm_rs2_sel, jump_branch_sel, mem_wr_en, reg_wr_en, reg_wr_en_wb} = '0;
    endtask

    // weighted pick, register indexes 0..3 so forwarding hits often
    task automatic drive_random_instr();
        logic [3:0] kind;
        logic [1:0] corner;
        kind            = take_bits(4);
        corner          = take_bits(2);
        rs1_data        = take_bits(32);
        rs2_data        = take_bits(32);
        imm             = take_bits(32);
        pc              = take_bits(32) & ~32'd3;
        pc_plus4        = pc + 32'd4;
        rs1             = take_bits(2);
        rs2             = take_bits(2);
        rd              = take_bits(2);
        funct3          = take_bits(3);
        funct7          = f7_base;
        wb_sel          = take_bits(2);
        wb_data         = take_bits(32);
        rd_wb           = take_bits(2);
        reg_wr_en_wb    = take_bits(1);
        pc_rs1_sel      = 1'b0;
        imm_rs2_sel     = 1'b0;
        jump_branch_sel = 1'b1;
        mem_wr_en       = 1'b0;
        reg_wr_en       = 1'b1;
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3: begin
                opcode = op_r;
                if (funct3 inside {f3_add_sub, f3_srl_sra} && take_bits(1)) begin
                    funct7 = f7_alt;
                end
            end
            4'd4, 4'd5: begin
                opcode = op_r;
                funct7 = f7_muldiv;
                funct3 = {1'b0, funct3[1:0]};
            end
            4'd6, 4'd7: begin
                opcode = op_r;
                funct7 = f7_muldiv;
                funct3 = {1'b1, funct3[1:0]};
                // corner operands come straight from registers nobody forwards into
                if (corner != 2'd3) begin
                    rs1          = rd_mem ^ 5'd1;
                    rs2          = rd_mem ^ 5'd1;
                    reg_wr_en_wb = 1'b0;
                end
                if (corner == 2'd0) begin
                    rs2_data = '0;
                end else if (corner == 2'd1) begin
                    rs1_data = 32'h8000_0000;
                    rs2_data = '1;
                end
            end
            4'd8, 4'd9, 4'd10: begin
                opcode      = op_i;
                imm_rs2_sel = 1'b1;
                if (funct3 == f3_srl_sra && take_bits(1)) begin
                    funct7 = f7_alt;
                end
            end
            4'd11: begin
                opcode      = op_lui;
                imm_rs2_sel = 1'b1;
            end
            4'd12: begin
                opcode      = op_auipc;
                pc_rs1_sel  = 1'b1;
                imm_rs2_sel = 1'b1;
            end
            4'd13: begin
                imm_rs2_sel = 1'b1;
                if (take_bits(1)) begin
                    opcode     = op_jal;
                    pc_rs1_sel = 1'b1;
                end else begin
                    // jalr target is rs1 + imm through the alu
                    opcode          = op_jalr;
                    jump_branch_sel = 1'b0;
                end
            end
            4'd14: begin
                opcode    = op_branch;
                reg_wr_en = 1'b0;
            end
            default: begin
                imm_rs2_sel = 1'b1;
                if (take_bits(1)) begin
                    opcode    = op_store;
                    mem_wr_en = 1'b1;
                    reg_wr_en = 1'b0;
                end else begin
                    opcode = op_load;
                end
            end
        endcase
    endtask

    initial begin
        clear_inputs();
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // a few empty cycles, EX/MEM has to stay clear
        repeat (2) @(negedge clk);
        for (int i = 0; i < num_instr; i++) begin
            drive_random_instr();
            @(negedge clk);
            // ID/EX holds still while the divider works
            if (div_stall) begin
                while (div_stall) begin
                    @(negedge clk);
                end
                // done cycle, the result enters EX/MEM at its closing edge
                @(negedge clk);
            end
        end
        clear_inputs();
        repeat (2) @(negedge clk);
        $display("checks failed: %0d", UUT.u_checker.err_count);
        if (UUT.u_checker.err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(clk_period * max_cycles);
        $display("timeout: the stimulus did not finish within %0d cycles", max_cycles);
        $display("sim failed");
        $finish;
    end

endmodule
